//--- sim.f
+incdir+design
design/flit_pkg.sv
design/router_pkg.sv
design/elastic_buffer.sv
design/input_port.sv
design/output_port.sv
design/mesh_router.sv
tests/router_checker.sv
tests/router_tb.sv

//--- run.sh
#!/bin/sh
# Build the mesh router testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -rf obj_dir

verilator --binary --assert -f sim.f --top-module router_tb -o router_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/router_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "PASS: all tests" "$LOG"; then
  exit 0
fi
echo "Simulation did not pass"
exit 1

//--- tests/router_tb.sv
// ------------------------------
// Testbench for the mesh router: random traffic on all ports, then a nic burst
// Checking is done by router_checker
// ------------------------------
`timescale 1ns/1ps
`include "noc_defs.svh"

module router_tb;
  import flit_pkg::*;
  import router_pkg::*;

  localparam int N              = `NUM_PORTS;
  localparam int FLITS_PER_PORT = 40;
  localparam int BURST_FLITS    = 8;
  localparam int TOTAL_FLITS    = N * FLITS_PER_PORT + 4 * BURST_FLITS;
  // 200 ns budget per flit
  localparam int WATCHDOG_NS    = 200 * TOTAL_FLITS;

  logic         clk;
  logic         reset;
  link_t        in_link  [N];
  logic [N-1:0] in_ready;
  link_t        out_link [N];
  logic [N-1:0] out_ready;
  logic         polarity;
  logic         burst_phase;
  logic         burst_vc;
  int           sent_count;
  int           recv_count;
  int           error_count;
  int           pending;

  // 4 ns period
  always #2 clk = ~clk;

  mesh_router i_dut (
    .clk             (clk),
    .reset           (reset),
    .in_link         (in_link),
    .in_ready        (in_ready),
    .out_link        (out_link),
    .out_ready       (out_ready),
    .polarity_to_nic (polarity)
  );

  router_checker i_checker (
    .clk         (clk),
    .reset       (reset),
    .in_link     (in_link),
    .in_ready    (in_ready),
    .out_link    (out_link),
    .out_ready   (out_ready),
    .polarity    (polarity),
    .burst_phase (burst_phase),
    .sent_count  (sent_count),
    .recv_count  (recv_count),
    .error_count (error_count),
    .pending     (pending)
  );

  // Sink readiness about 70% high, held high for the burst
  always @(negedge clk) begin
    for (int p = 0; p < N; p++) begin
      out_ready[p] = burst_phase || ($urandom_range(99) < 70);
    end
  end

  // Drive count flits into one port, each held until in_ready takes it
  task automatic send_flits(input int port, input int count, input bit burst);
    flit_t f;
    for (int seq = 0; seq < count; seq++) begin
      f         = '0;
      f.vc      = burst ? burst_vc : 1'($urandom_range(1));
      f.x_dir   = 1'($urandom_range(1));
      f.y_dir   = 1'($urandom_range(1));
      // Burst flits are local, so they all head for nic
      f.hop_x   = burst ? '0 : 4'($urandom_range(3));
      f.hop_y   = burst ? '0 : 4'($urandom_range(3));
      f.payload = {8'(port), 24'($urandom), 16'(seq)};
      @(negedge clk);
      in_link[port] = '{valid: 1'b1, flit: f};
      do @(posedge clk); while (!in_ready[port]);
    end
    @(negedge clk);
    in_link[port].valid = 1'b0;
  endtask

  initial begin
    void'($urandom(68827));
    clk         = 1'b0;
    reset       = 1'b1;
    burst_phase = 1'b0;
    burst_vc    = 1'($urandom_range(1));
    out_ready   = '0;
    for (int p = 0; p < N; p++) begin
      in_link[p] = '0;
    end
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset <= 1'b0;

    // ------------------------------
    // Random traffic, all ports at once
    // ------------------------------
    fork
      send_flits(int'(PORT_UP), FLITS_PER_PORT, 1'b0);
      send_flits(int'(PORT_DOWN), FLITS_PER_PORT, 1'b0);
      send_flits(int'(PORT_LEFT), FLITS_PER_PORT, 1'b0);
      send_flits(int'(PORT_RIGHT), FLITS_PER_PORT, 1'b0);
      send_flits(int'(PORT_NIC), FLITS_PER_PORT, 1'b0);
    join
    wait (pending == 0);

    // ------------------------------
    // Burst of one VC class into nic
    // ------------------------------
    @(negedge clk);
    burst_phase <= 1'b1;
    fork
      send_flits(int'(PORT_UP), BURST_FLITS, 1'b1);
      send_flits(int'(PORT_DOWN), BURST_FLITS, 1'b1);
      send_flits(int'(PORT_LEFT), BURST_FLITS, 1'b1);
      send_flits(int'(PORT_RIGHT), BURST_FLITS, 1'b1);
    join
    wait (pending == 0);
    @(negedge clk);

    $display("Summary: %0d flits sent, %0d delivered, %0d errors",
             sent_count, recv_count, error_count);
    if (error_count == 0 && sent_count == TOTAL_FLITS) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("Timeout after %0d ns with %0d flits still in flight", WATCHDOG_NS, pending);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

//--- tests/router_checker.sv
// ------------------------------
// Scoreboard and protocol monitor for the mesh router
// Watches the DUT ports, counts flits and every mismatch
// ------------------------------
`timescale 1ns/1ps
`include "noc_defs.svh"

module router_checker (
  input  logic                  clk,
  input  logic                  reset,
  input  router_pkg::link_t     in_link  [`NUM_PORTS],
  input  logic [`NUM_PORTS-1:0] in_ready,
  input  router_pkg::link_t     out_link [`NUM_PORTS],
  input  logic [`NUM_PORTS-1:0] out_ready,
  input  logic                  polarity,
  input  logic                  burst_phase,
  output int                    sent_count,
  output int                    recv_count,
  output int                    error_count,
  output int                    pending
);
  import flit_pkg::*;
  import router_pkg::*;

  localparam int N = `NUM_PORTS;

  // One queue per source and destination pair at index src * N + dst
  flit_t        exp_q [N*N][$];
  link_t        prev_out [N];
  logic [N-1:0] prev_ready;
  logic         exp_pol;
  // Bit o of since_last[s] is set once o reached nic after s did
  logic [N-1:0] since_last [N];
  logic [N-1:0] nic_seen;

  assign pending = sent_count - recv_count;

  initial begin
    sent_count  = 0;
    recv_count  = 0;
    error_count = 0;
    nic_seen    = '0;
    exp_pol     = 1'b0;
    for (int s = 0; s < N; s++) begin
      since_last[s] = '0;
    end
  end

  // ------------------------------
  // Reference routing goes X first, then Y, else local
  // ------------------------------
  function automatic flit_t expected_route(input flit_t f, output port_e dest);
    flit_t nxt;
    nxt = f;
    if (f.hop_x != '0) begin
      dest      = f.x_dir ? PORT_LEFT : PORT_RIGHT;
      nxt.hop_x = f.hop_x - 1'b1;
    end else if (f.hop_y != '0) begin
      dest      = f.y_dir ? PORT_DOWN : PORT_UP;
      nxt.hop_y = f.hop_y - 1'b1;
    end else begin
      dest = PORT_NIC;
    end
    return nxt;
  endfunction

  task automatic report_mismatch(input string sig, input logic [63:0] got,
                                 input logic [63:0] exp);
    $display("[ERROR] %0t %s got %h expected %h", $time, sig, got, exp);
    error_count++;
  endtask

  // In the burst every other source with flits waiting must go before s repeats
  task automatic check_fairness(input int s);
    for (int o = 0; o < N; o++) begin
      if (o != s && nic_seen[s] && exp_q[o*N + int'(PORT_NIC)].size() > 0
          && !since_last[s][o]) begin
        $display("[ERROR] %0t round robin skipped source %0d between two grants to source %0d",
                 $time, o, s);
        error_count++;
      end
    end
    nic_seen[s]   = 1'b1;
    since_last[s] = '0;
    for (int o = 0; o < N; o++) begin
      since_last[o][s] = 1'b1;
    end
  endtask

  // Match a delivered flit against the heads of the five source queues
  task automatic deliver(input int d, input flit_t f);
    int src;
    bit found;
    found = 1'b0;
    src   = 0;
    for (int s = 0; s < N; s++) begin
      if (!found && exp_q[s*N + d].size() > 0 && exp_q[s*N + d][0] === f) begin
        void'(exp_q[s*N + d].pop_front());
        found = 1'b1;
        src   = s;
      end
    end
    if (found) begin
      recv_count++;
      if (burst_phase && d == int'(PORT_NIC)) begin
        check_fairness(src);
      end
    end else begin
      // Source port sits in the top payload byte
      src = int'(f.payload[47:40]);
      if (src < N && exp_q[src*N + d].size() > 0) begin
        report_mismatch($sformatf("out_link[%0d].flit", d), f, exp_q[src*N + d][0]);
      end else begin
        $display("[ERROR] %0t out_link[%0d] delivered flit %h that was never sent there",
                 $time, d, f);
        error_count++;
      end
    end
  endtask

  // ------------------------------
  // Edge monitor
  // ------------------------------
  always @(posedge clk) begin
    flit_t nxt;
    port_e dest;
    if (reset) begin
      exp_pol = 1'b0;
    end else begin
      // Polarity starts at 0 and flips every edge
      if (polarity !== exp_pol) begin
        report_mismatch("polarity_to_nic", 64'(polarity), 64'(exp_pol));
      end
      exp_pol = ~exp_pol;
      // Accepted inputs go into their queues
      for (int p = 0; p < N; p++) begin
        if (in_link[p].valid && in_ready[p]) begin
          nxt = expected_route(in_link[p].flit, dest);
          exp_q[p*N + int'(dest)].push_back(nxt);
          sent_count++;
        end
      end
      // Stalled outputs keep valid and flit
      for (int d = 0; d < N; d++) begin
        if (prev_out[d].valid && !prev_ready[d]) begin
          if (out_link[d].valid !== 1'b1) begin
            report_mismatch($sformatf("out_link[%0d].valid", d), 64'(out_link[d].valid), 64'd1);
          end else if (out_link[d].flit !== prev_out[d].flit) begin
            report_mismatch($sformatf("out_link[%0d].flit", d), out_link[d].flit,
                            prev_out[d].flit);
          end
        end
        if (out_link[d].valid && out_ready[d]) begin
          deliver(d, out_link[d].flit);
        end
      end
    end
    prev_out   = out_link;
    prev_ready = out_ready;
  end

  // Outputs stay idle and inputs ready while reset is held
  always @(negedge clk) begin
    if (reset) begin
      for (int d = 0; d < N; d++) begin
        if (out_link[d].valid !== 1'b0) begin
          report_mismatch($sformatf("out_link[%0d].valid", d), 64'(out_link[d].valid), 64'd0);
        end
      end
      if (in_ready !== {N{1'b1}}) begin
        report_mismatch("in_ready", 64'(in_ready), 64'({N{1'b1}}));
      end
    end
  end

endmodule

//--- design/mesh_router.sv
// ----------------------------
// Five-port mesh router with two VC classes in alternate cycles
// Polarity toggles each cycle and is shown to the NIC
// ----------------------------
`timescale 1ns/1ps
`include "noc_defs.svh"

module mesh_router (
  input  logic                  clk,
  input  logic                  reset,
  input  router_pkg::link_t     in_link  [`NUM_PORTS],
  output logic [`NUM_PORTS-1:0] in_ready,
  output router_pkg::link_t     out_link [`NUM_PORTS],
  input  logic [`NUM_PORTS-1:0] out_ready,
  output logic                  polarity_to_nic
);
  import flit_pkg::*;
  import router_pkg::*;

  localparam int N = `NUM_PORTS;

  logic         polarity;
  req_t         req        [N];
  flit_t        req_flit   [N];
  // Indexed by output port, bit i belongs to input i
  logic [N-1:0] req_col    [N];
  logic [N-1:0] grant_acc  [N];
  logic [N-1:0] accept;

  // ----------------------------
  // VC slot polarity
  // ----------------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      polarity <= 1'b0;
    end else begin
      polarity <= ~polarity;
    end
  end

  assign polarity_to_nic = polarity;

  // ----------------------------
  // Ports and crossbar
  // ----------------------------
  for (genvar p = 0; p < N; p++) begin : g_port
    input_port i_in (
      .clk      (clk),
      .reset    (reset),
      .in_link  (in_link[p]),
      .in_ready (in_ready[p]),
      .req      (req[p]),
      .accept   (accept[p])
    );

    assign req_flit[p] = req[p].flit;

    // Output p sees bit p of every request
    for (genvar i = 0; i < N; i++) begin : g_col
      assign req_col[p][i] = req[i].dest[p];
    end

    output_port i_out (
      .clk          (clk),
      .reset        (reset),
      .polarity     (polarity),
      .req_valid    (req_col[p]),
      .req_flit     (req_flit),
      .grant_accept (grant_acc[p]),
      .out_link     (out_link[p]),
      .out_ready    (out_ready[p])
    );
  end

  // Input i pops when any output accepts it
  always_comb begin
    accept = '0;
    for (int p = 0; p < N; p++) begin
      accept = accept | grant_acc[p];
    end
  end

  // Whatever reaches the NIC has finished both axes
  a_nic_local: assert property (@(posedge clk) disable iff (reset)
    out_link[PORT_NIC].valid |->
      (out_link[PORT_NIC].flit.hop_x == '0) && (out_link[PORT_NIC].flit.hop_y == '0));

endmodule

//--- design/output_port.sv
// ----------------------------
// Router output stage: round robin over the five inputs
// Takes a flit only in its VC slot and holds it for the link
// ----------------------------
`timescale 1ns/1ps
`include "noc_defs.svh"

module output_port (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  polarity,
  input  logic [`NUM_PORTS-1:0] req_valid,
  input  flit_pkg::flit_t       req_flit [`NUM_PORTS],
  output logic [`NUM_PORTS-1:0] grant_accept,
  output router_pkg::link_t     out_link,
  input  logic                  out_ready
);
  import flit_pkg::*;

  localparam int N = `NUM_PORTS;

  logic [N-1:0] ptr;
  logic [N-1:0] grant;
  flit_t        sel_flit;
  logic         vc_match;
  logic         ob_ready;
  logic         push;
  logic         ob_valid;
  flit_t        ob_flit;

  // ----------------------------
  // Round-robin grant
  // ----------------------------
  // First requester at or after the pointer
  // Offsets scanned high to low so the nearest one wins
  always_comb begin
    grant = '0;
    for (int i = 0; i < N; i++) begin
      if (ptr[i]) begin
        for (int k = N - 1; k >= 0; k--) begin
          if (req_valid[(i + k) % N]) begin
            grant                = '0;
            grant[(i + k) % N]   = 1'b1;
          end
        end
      end
    end
  end

  // Flit of the granted input
  always_comb begin
    sel_flit = '0;
    for (int i = 0; i < N; i++) begin
      if (grant[i]) begin
        sel_flit = req_flit[i];
      end
    end
  end

  // Strict VC slotting on the push side
  assign vc_match     = (sel_flit.vc == polarity);
  assign push         = (|grant) && vc_match && ob_ready;
  assign grant_accept = push ? grant : '0;

  // Pointer moves one past the winner, only on a real push
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ptr <= {{(N - 1){1'b0}}, 1'b1};
    end else if (push) begin
      ptr <= {grant[N-2:0], grant[N-1]};
    end
  end

  // ----------------------------
  // Output buffer
  // ----------------------------
  elastic_buffer i_obuf (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (push),
    .in_data   (sel_flit),
    .in_ready  (ob_ready),
    .out_valid (ob_valid),
    .out_data  (ob_flit),
    .out_ready (out_ready)
  );

  assign out_link = '{valid: ob_valid, flit: ob_flit};

  a_accept_onehot0: assert property (@(posedge clk) disable iff (reset)
    $onehot0(grant_accept));

endmodule

//--- design/input_port.sv
// ----------------------------
// Router input stage: buffers one flit and routes it X first, then Y
// Hop counter of the axis taken is counted down here
// ----------------------------
`timescale 1ns/1ps

module input_port (
  input  logic              clk,
  input  logic              reset,
  input  router_pkg::link_t in_link,
  output logic              in_ready,
  output router_pkg::req_t  req,
  input  logic              accept
);
  import flit_pkg::*;
  import router_pkg::*;

  logic  buf_valid;
  flit_t buf_flit;
  flit_t nxt_flit;
  port_e route;

  // ----------------------------
  // Input buffer
  // ----------------------------
  // Pops when the chosen output takes the flit
  elastic_buffer i_ibuf (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_link.valid),
    .in_data   (in_link.flit),
    .in_ready  (in_ready),
    .out_valid (buf_valid),
    .out_data  (buf_flit),
    .out_ready (accept)
  );

  // ----------------------------
  // Route decision
  // ----------------------------
  always_comb begin
    nxt_flit = buf_flit;
    route    = PORT_NIC;
    if (buf_flit.hop_x != '0) begin
      // X axis first
      route          = buf_flit.x_dir ? PORT_LEFT : PORT_RIGHT;
      nxt_flit.hop_x = buf_flit.hop_x - 1'b1;
    end else if (buf_flit.hop_y != '0) begin
      // Then Y axis
      route          = buf_flit.y_dir ? PORT_DOWN : PORT_UP;
      nxt_flit.hop_y = buf_flit.hop_y - 1'b1;
    end
    // Both counters zero means local delivery
  end

  // Request only while a flit is held
  assign req.dest = buf_valid ? port_bit(route) : '0;
  assign req.flit = nxt_flit;

  // A held flit asks for exactly one output
  a_req_onehot: assert property (@(posedge clk) disable iff (reset)
    buf_valid |-> $onehot(req.dest));

endmodule

//--- design/elastic_buffer.sv
// ----------------------------
// One-entry elastic buffer with valid/ready on both sides
// Used in front of and behind the crossbar
// ----------------------------
`timescale 1ns/1ps

module elastic_buffer (
  input  logic            clk,
  input  logic            reset,
  input  logic            in_valid,
  input  flit_pkg::flit_t in_data,
  output logic            in_ready,
  output logic            out_valid,
  output flit_pkg::flit_t out_data,
  input  logic            out_ready
);
  import flit_pkg::*;

  logic  full;
  flit_t data_q;
  logic  push;
  logic  pop;

  // Entry leaves when downstream takes it
  assign pop      = full && out_ready;
  // Room when empty, or when the held flit goes out this cycle
  assign in_ready = !full || pop;
  assign push     = in_valid && in_ready;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      full <= 1'b0;
    end else if (push) begin
      // Push wins over pop, covers pass-through
      full <= 1'b1;
    end else if (pop) begin
      full <= 1'b0;
    end
  end

  // Payload register
  always_ff @(posedge clk) begin
    if (push) begin
      data_q <= in_data;
    end
  end

  assign out_valid = full;
  assign out_data  = data_q;

  // Held flit stays put until it is taken
  a_hold_stable: assert property (@(posedge clk) disable iff (reset)
    out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

//--- design/router_pkg.sv
// ----------------------------
// Router port names and the structs used on links and in the crossbar
// ----------------------------
`include "noc_defs.svh"

package router_pkg;

  // Port numbering, also the bit order of every 5-bit vector
  typedef enum logic [2:0] {
    PORT_UP    = 3'd0,
    PORT_DOWN  = 3'd1,
    PORT_LEFT  = 3'd2,
    PORT_RIGHT = 3'd3,
    PORT_NIC   = 3'd4
  } port_e;

  // Forward half of a link, ready travels on its own
  typedef struct packed {
    logic            valid;
    flit_pkg::flit_t flit;
  } link_t;

  // Input port to crossbar, one-hot destination plus the updated flit
  typedef struct packed {
    logic [`NUM_PORTS-1:0] dest;
    flit_pkg::flit_t       flit;
  } req_t;

  // One-hot vector with the bit of port p set
  function automatic logic [`NUM_PORTS-1:0] port_bit(port_e p);
    logic [`NUM_PORTS-1:0] onehot;
    onehot    = '0;
    onehot[p] = 1'b1;
    return onehot;
  endfunction

endpackage

//--- design/flit_pkg.sv
// ----------------------------
// Flit format shared by the router and the testbench
// ----------------------------
`include "noc_defs.svh"

package flit_pkg;

  // ----------------------------
  // Flit layout, top bit first
  // ----------------------------
  typedef struct packed {
    // VC class, matched against the polarity slot
    logic                  vc;
    // 0 moves right, 1 moves left
    logic                  x_dir;
    // 0 moves up, 1 moves down
    logic                  y_dir;
    logic [`RSVD_W-1:0]    reserved;
    // Hops still to go along X
    logic [`HOP_W-1:0]     hop_x;
    // Hops still to go along Y, used once X is done
    logic [`HOP_W-1:0]     hop_y;
    // Opaque to the router
    logic [`PAYLOAD_W-1:0] payload;
  } flit_t;

endpackage

//--- design/noc_defs.svh
// ----------------------------
// Flit geometry and router size for the mesh router
// Include anywhere these sizes are needed
// ----------------------------
`ifndef NOC_DEFS_SVH
`define NOC_DEFS_SVH

// Whole flit as carried on every link
`define FLIT_W 64

// One hop counter per axis
`define HOP_W 4

// up, down, left, right, nic
`define NUM_PORTS 5

// Payload sits in the low bits of the flit
`define PAYLOAD_W 48

// Reserved field fills the gap under vc, x_dir and y_dir
`define RSVD_W (`FLIT_W - 3 - 2 * `HOP_W - `PAYLOAD_W)

`endif
